// ==== bench/tb_supervised_synapse.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_supervised_synapse;
    import synapse_pkg::*;

    // four tests of reset plus hold plus program plus stalls, times two
    localparam int CYCLE_LIMIT = 4 * (8 + TARGET_RESET_HOLD + 13 + 64) * 2;

    // program reads r0, r1 and r3 on the external bus
    localparam logic [TOP_REG:0] EXP_READS = 16'b0000_0000_0000_1011;

    logic                 sysclk;
    logic                 rst_n;
    logic                 mcu_wait;
    logic [15:0]          r [0:TOP_REG];
    logic [TOP_REG:0]     r_read;
    logic [TOP_REG:0]     r_load;
    logic [15:0]          r_load_data;
    logic [15:0]          av_address;
    logic [15:0]          av_writedata;
    logic                 av_write;
    logic                 av_waitrequest;

    // register file model and avalon slave bookkeeping
    logic [15:0]          reg_model [0:TOP_REG];
    logic [TOP_REG:0]     reg_written;
    logic [TOP_REG:0]     reg_read_seen;
    int                   rec_count;
    logic                 halt_done;
    logic [15:0]          exp_addr [0:2];
    logic [15:0]          exp_data [0:2];
    logic [15:0]          exp_sum;
    logic [15:0]          exp_xor;

    logic [15:0]          lfsr;
    int                   err_count;
    int                   cycle_count;
    int                   since_reset;
    int                   tests_run;
    int                   tests_failed;

    supervised_synapse uut (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .mcu_wait           (mcu_wait),
        .r                  (r),
        .r_read             (r_read),
        .r_load             (r_load),
        .r_load_data        (r_load_data),
        .dbg_av_address     (av_address),
        .dbg_av_writedata   (av_writedata),
        .dbg_av_write       (av_write),
        .dbg_av_waitrequest (av_waitrequest)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    // fibonacci form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // register file capture and avalon slave on the rising edge
    always @(posedge sysclk) begin
        if (!rst_n) begin
            reg_written = '0;
            reg_read_seen = '0;
            rec_count = 0;
            halt_done = 1'b0;
        end else begin
            reg_read_seen = reg_read_seen | r_read;
            for (int i = 0; i <= TOP_REG; i++) begin
                if (r_load[i]) begin
                    reg_model[i] = r_load_data;
                    reg_written[i] = 1'b1;
                end
            end
            if (av_write && !av_waitrequest) begin
                // halt record is the last one
                assert (rec_count < 3)
                else begin
                    err_count++;
                    $display("** Error at %0t: extra avalon write to %h after the halt record",
                             $time, av_address);
                end
                if (rec_count < 3) begin
                    assert (av_address == exp_addr[rec_count]
                            && av_writedata == exp_data[rec_count])
                    else begin
                        err_count++;
                        $display("** Error at %0t: record %0d is %h/%h, expected %h/%h",
                                 $time, rec_count, av_address, av_writedata,
                                 exp_addr[rec_count], exp_data[rec_count]);
                    end
                end
                if (av_address == HALT_ADDR) begin
                    halt_done = 1'b1;
                end
                rec_count++;
            end
        end
    end

    // cycles since rst_n rose for the reset-quiet window
    always @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            since_reset <= 0;
        end else if (since_reset < 1000) begin
            since_reset <= since_reset + 1;
        end
    end

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge sysclk);
        end
        $display("timeout after %0d cycles, the program never halted", cycle_count);
        $display("Test FAILED");
        $finish;
    end

    // address and data held under back-pressure
    a_hold_stable: assert property (@(posedge sysclk) disable iff (!rst_n)
        av_write && av_waitrequest |=> av_write && $stable(av_address)
                                       && $stable(av_writedata))
    else begin
        err_count++;
        $display("** Error at %0t: avalon write changed while waitrequest was high", $time);
    end

    // target frozen while a record is pending
    a_no_load_pending: assert property (@(posedge sysclk) disable iff (!rst_n)
        av_write |-> r_load == '0)
    else begin
        err_count++;
        $display("** Error at %0t: r_load %h while a record was pending", $time, r_load);
    end

    // no register traffic while the mcu holds the target
    a_wait_quiet: assert property (@(posedge sysclk) disable iff (!rst_n)
        mcu_wait |-> r_read == '0 && r_load == '0)
    else begin
        err_count++;
        $display("** Error at %0t: register strobe while mcu_wait high", $time);
    end

    // quiet in reset and through the target hold
    a_reset_quiet: assert property (@(posedge sysclk)
        (!rst_n || since_reset < TARGET_RESET_HOLD)
            |-> r_read == '0 && r_load == '0 && !av_write)
    else begin
        err_count++;
        $display("** Error at %0t: activity during reset hold", $time);
    end

    // peek strobe never leaves the subsystem
    a_top_bit: assert property (@(posedge sysclk)
        !r_read[DEBUG_PEEK_REG] && !r_load[DEBUG_PEEK_REG])
    else begin
        err_count++;
        $display("** Error at %0t: bit 15 of r_read or r_load set", $time);
    end

    // final register contents against the program's arithmetic
    task automatic check_results;
        assert (reg_written[2] && reg_model[2] == exp_sum)
        else begin
            err_count++;
            $display("** Error at %0t: r2 is %h, expected %h", $time, reg_model[2], exp_sum);
        end
        assert (reg_written[4] && reg_model[4] == exp_xor)
        else begin
            err_count++;
            $display("** Error at %0t: r4 is %h, expected %h", $time, reg_model[4], exp_xor);
        end
        assert (reg_written[6] && reg_model[6] == 16'h0123)
        else begin
            err_count++;
            $display("** Error at %0t: r6 is %h, expected 0123", $time, reg_model[6]);
        end
        if (exp_xor != 16'd0) begin
            assert (reg_written[5] && reg_model[5] == exp_xor)
            else begin
                err_count++;
                $display("** Error at %0t: r5 is %h, expected %h",
                         $time, reg_model[5], exp_xor);
            end
        end else begin
            assert (!reg_written[5])
            else begin
                err_count++;
                $display("** Error at %0t: r5 written although the skip was due", $time);
            end
        end
        assert (reg_read_seen == EXP_READS)
        else begin
            err_count++;
            $display("** Error at %0t: registers read %h, expected %h",
                     $time, reg_read_seen, EXP_READS);
        end
        assert (rec_count == 3)
        else begin
            err_count++;
            $display("** Error at %0t: %0d avalon writes, expected 3", $time, rec_count);
        end
    endtask

    task automatic run_test(input int num, input string name,
                            input logic back_pressure, input logic stall,
                            input logic zero_xor);
        logic [15:0] v;
        int          errs_before;
        errs_before = err_count;
        @(negedge sysclk);
        rst_n = 1'b0;
        mcu_wait = 1'b0;
        av_waitrequest = 1'b0;
        for (int i = 0; i < 4; i++) begin
            random_bits(16, v);
            r[i] = v;
        end
        // r3 cancels the sum so the skip is taken
        if (zero_xor) begin
            r[3] = r[0] + r[1];
        end
        exp_sum = r[0] + r[1];
        exp_xor = exp_sum ^ r[3];
        exp_addr[0] = TRACE_BASE | 16'd3;
        exp_data[0] = exp_sum;
        exp_addr[1] = TRACE_BASE | 16'd9;
        exp_data[1] = exp_xor;
        exp_addr[2] = HALT_ADDR;
        exp_data[2] = 16'd12;
        repeat (8) @(negedge sysclk);
        rst_n = 1'b1;
        while (!halt_done) begin
            @(negedge sysclk);
            if (back_pressure) begin
                random_bits(2, v);
                av_waitrequest = (v[1:0] != 2'd0);
            end
            if (stall) begin
                random_bits(1, v);
                mcu_wait = v[0];
            end
        end
        av_waitrequest = 1'b0;
        mcu_wait = 1'b0;
        // nothing more may arrive while draining
        repeat (4) @(negedge sysclk);
        check_results();
        tests_run++;
        if (err_count == errs_before) begin
            $display("[%0d] %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("[%0d] %s: %0d errors", num, name, err_count - errs_before);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        mcu_wait = 1'b0;
        av_waitrequest = 1'b0;
        for (int i = 0; i <= TOP_REG; i++) begin
            r[i] = 16'd0;
            reg_model[i] = 16'd0;
        end
        lfsr = 16'd5336;
        err_count = 0;
        tests_run = 0;
        tests_failed = 0;
        run_test(1, "arithmetic and trace", 1'b0, 1'b0, 1'b0);
        run_test(2, "waitrequest back-pressure", 1'b1, 1'b0, 1'b0);
        run_test(3, "mcu_wait stall", 1'b0, 1'b1, 1'b0);
        run_test(4, "zero xor skip", 1'b1, 1'b1, 1'b1);
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/synapse_pkg.sv
rtl/target_program.sv
rtl/synapse_core.sv
rtl/debug_visor.sv
rtl/supervised_synapse.sv
bench/tb_supervised_synapse.sv

// ==== rtl/debug_visor.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_visor (
    input  wire logic                       sysclk,
    input  wire logic                       rst_n,
    input  wire logic                       mcu_wait,

    // fetch path between rom and target
    input  wire synapse_pkg::instr_u        rom_code_in,
    output synapse_pkg::instr_u             tg_code,
    output logic                            tg_code_ready,

    // target control and status
    output logic                            tg_rst_n,
    input  wire synapse_pkg::debug_out_s    tg_debug_out,

    // peek register
    input  wire logic                       tg_peek_load,
    input  wire logic [15:0]                tg_load_data,
    output logic [15:0]                     peek_data,

    // avalon-mm master, write only
    output logic [15:0]                     av_address,
    output logic [15:0]                     av_writedata,
    input  wire logic                       av_waitrequest,
    output logic                            av_write
);
    import synapse_pkg::*;

    // reset hold counter
    logic [HOLD_CNT_W-1:0] hold_cnt;

    // trace slot
    logic       slot_valid;
    logic       slot_load;
    logic       slot_done;
    trace_rec_s slot;
    trace_rec_s slot_next;

    // target reset release
    // low while rst_n is low, then TARGET_RESET_HOLD more cycles
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= '0;
            tg_rst_n <= 1'b0;
        end else if (!tg_rst_n) begin
            if (hold_cnt == HOLD_CNT_W'(TARGET_RESET_HOLD - 1)) begin
                tg_rst_n <= 1'b1;
            end else begin
                hold_cnt <= hold_cnt + HOLD_CNT_W'(1);
            end
        end
    end

    // peek register, captured on a store to DEBUG_PEEK_REG
    always_ff @(posedge sysclk) begin
        if (tg_peek_load) begin
            peek_data <= tg_load_data;
        end
    end

    // new record on a peek store or on the halt
    // both only happen on a ready edge, so the slot is free
    assign slot_load = tg_peek_load || tg_debug_out.halt_now;

    // write accepted by the slave
    assign slot_done = slot_valid && !av_waitrequest;

    // record contents
    always_comb begin
        if (tg_debug_out.halt_now) begin
            // halt record carries the halting pc
            slot_next.addr = HALT_ADDR;
            slot_next.data = tg_debug_out.pc;
        end else begin
            // peek record tagged with the storing pc
            slot_next.addr = TRACE_BASE | tg_debug_out.pc;
            slot_next.data = tg_load_data;
        end
    end

    // slot occupancy
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
        end else if (slot_load) begin
            slot_valid <= 1'b1;
        end else if (slot_done) begin
            slot_valid <= 1'b0;
        end
    end

    // slot payload
    // held untouched until the write completes
    always_ff @(posedge sysclk) begin
        if (slot_load) begin
            slot <= slot_next;
        end
    end

    // master port straight from the slot
    assign av_write = slot_valid;
    assign av_address = slot.addr;
    assign av_writedata = slot.data;

    // word passes through, delivery is gated by ready
    assign tg_code = rom_code_in;

    // stall the target
    // in reset, external wait, record pending, or halted
    assign tg_code_ready = tg_rst_n
                           && !mcu_wait
                           && !slot_valid
                           && !tg_debug_out.halted;

endmodule

`default_nettype wire

// ==== rtl/supervised_synapse.sv ====
`timescale 1ns/1ps
`default_nettype none

module supervised_synapse (
    input  wire logic                           sysclk,
    input  wire logic                           rst_n,
    input  wire logic                           mcu_wait,

    // register file outside the subsystem
    input  wire logic [15:0]                    r [0:synapse_pkg::TOP_REG],
    output wire logic [synapse_pkg::TOP_REG:0]  r_read,
    output wire logic [synapse_pkg::TOP_REG:0]  r_load,
    output wire logic [15:0]                    r_load_data,

    // trace port, avalon-mm master
    output wire logic [15:0]                    dbg_av_address,
    output wire logic [15:0]                    dbg_av_writedata,
    output wire logic                           dbg_av_write,
    input  wire logic                           dbg_av_waitrequest
);
    import synapse_pkg::*;

    // fetch path
    instr_u           rom_code;
    instr_u           tg_code;
    logic [15:0]      tg_code_addr;
    logic             tg_code_ready;
    logic             tg_rst_n;

    // target side of the register file
    wire logic [15:0] tg_r [0:TOP_REG];
    logic [TOP_REG:0] tg_r_read;
    logic [TOP_REG:0] tg_r_load;
    logic [15:0]      peek_data;

    debug_out_s       tg_debug_out;

    target_program rom (
        .addr (tg_code_addr),
        .data (rom_code)
    );

    synapse_core target (
        .sysclk      (sysclk),
        .rst_n       (tg_rst_n),
        .code_addr   (tg_code_addr),
        .code_in     (tg_code),
        .code_ready  (tg_code_ready),
        .r           (tg_r),
        .r_read      (tg_r_read),
        .r_load      (tg_r_load),
        .r_load_data (r_load_data),
        .debug_out   (tg_debug_out)
    );

    // peek register sits on top of the target's register file
    assign tg_r[0:DEBUG_PEEK_REG-1] = r[0:DEBUG_PEEK_REG-1];
    assign tg_r[DEBUG_PEEK_REG] = peek_data;

    // top strobe never leaves the subsystem
    assign r_read = {1'b0, tg_r_read[DEBUG_PEEK_REG-1:0]};
    assign r_load = {1'b0, tg_r_load[DEBUG_PEEK_REG-1:0]};

    debug_visor visr (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .mcu_wait       (mcu_wait),
        .rom_code_in    (rom_code),
        .tg_code        (tg_code),
        .tg_code_ready  (tg_code_ready),
        .tg_rst_n       (tg_rst_n),
        .tg_debug_out   (tg_debug_out),
        .tg_peek_load   (tg_r_load[DEBUG_PEEK_REG]),
        .tg_load_data   (r_load_data),
        .peek_data      (peek_data),
        .av_address     (dbg_av_address),
        .av_writedata   (dbg_av_writedata),
        .av_waitrequest (dbg_av_waitrequest),
        .av_write       (dbg_av_write)
    );

endmodule

`default_nettype wire

// ==== rtl/synapse_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module synapse_core (
    input  wire logic                           sysclk,
    input  wire logic                           rst_n,

    // instruction fetch
    output logic [15:0]                         code_addr,
    input  wire synapse_pkg::instr_u            code_in,
    input  wire logic                           code_ready,

    // register file, external plus peek
    input  wire logic [15:0]                    r [0:synapse_pkg::TOP_REG],
    output logic [synapse_pkg::TOP_REG:0]       r_read,
    output logic [synapse_pkg::TOP_REG:0]       r_load,
    output logic [15:0]                         r_load_data,

    // status to the supervisor
    output synapse_pkg::debug_out_s             debug_out
);
    import synapse_pkg::*;

    // architectural state
    logic [15:0] pc;
    logic [15:0] a;
    logic        skip;
    logic        halted;

    // decode
    logic        step;
    logic        live;
    logic        is_move;
    op_e         op;
    logic [3:0]  src;
    logic [3:0]  dst;
    logic [15:0] src_val;
    logic        halt_now;

    // pc goes straight out as the fetch address
    assign code_addr = pc;

    // one instruction per ready edge
    assign step = code_ready && !halted;
    // skipped slot still consumes the step
    assign live = step && !skip;

    // move view fields
    assign is_move = !code_in.mov.is_imm;
    assign op = code_in.mov.op;
    assign src = code_in.mov.src;
    assign dst = code_in.mov.dst;

    // source operand, sampled at the executing edge
    assign src_val = r[src];

    // stores always carry the accumulator
    assign r_load_data = a;

    // register strobes only in the executing cycle
    always_comb begin
        r_read = '0;
        r_load = '0;
        if (live && is_move) begin
            case (op)
                OP_LOAD, OP_ADD, OP_XOR: begin
                    r_read[src] = 1'b1;
                end
                OP_STORE: begin
                    r_load[dst] = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // high only in the cycle the halt executes
    assign halt_now = live && is_move && (op == OP_HALT);

    always_comb begin
        debug_out.pc = pc;
        debug_out.halted = halted;
        debug_out.halt_now = halt_now;
    end

    // pc, accumulator, skip and halt flags
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= 16'd0;
            a <= 16'd0;
            skip <= 1'b0;
            halted <= 1'b0;
        end else if (step) begin
            // default advance, jump and halt override below
            pc <= pc + 16'd1;
            // a skip lasts exactly one slot
            skip <= 1'b0;
            if (!skip) begin
                if (code_in.imm.is_imm) begin
                    // immediate view
                    a <= {1'b0, code_in.imm.literal};
                end else begin
                    case (op)
                        OP_LOAD: begin
                            a <= src_val;
                        end
                        OP_ADD: begin
                            a <= a + src_val;
                        end
                        OP_XOR: begin
                            a <= a ^ src_val;
                        end
                        OP_JUMP: begin
                            pc <= a;
                        end
                        OP_SKIPZ: begin
                            skip <= (a == 16'd0);
                        end
                        OP_HALT: begin
                            // pc stays on the halt for the record
                            pc <= pc;
                            halted <= 1'b1;
                        end
                        default: begin
                            // store has no core-side effect
                            // beyond the strobe above
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/synapse_pkg.sv ====
`default_nettype none

package synapse_pkg;

    // register map
    // r[0..14] live outside, r[15] is the peek register inside the visor
    localparam int TOP_REG = 15;
    localparam int DEBUG_PEEK_REG = TOP_REG;

    // trace record addresses on the avalon master
    // peek records carry the storing pc in the low bits
    localparam logic [15:0] TRACE_BASE = 16'h8000;
    localparam logic [15:0] HALT_ADDR = 16'hFFFE;

    // target held in reset this many cycles after rst_n rises
    localparam int TARGET_RESET_HOLD = 4;
    localparam int HOLD_CNT_W = $clog2(TARGET_RESET_HOLD + 1);

    // move-form operations
    typedef enum logic [2:0] {
        OP_LOAD,
        OP_STORE,
        OP_ADD,
        OP_XOR,
        OP_JUMP,
        OP_SKIPZ,
        OP_HALT
    } op_e;

    // immediate view, literal zero-extended into a
    typedef struct packed {
        logic        is_imm;
        logic [14:0] literal;
    } imm_view_s;

    // move view, is_imm low
    typedef struct packed {
        logic       is_imm;
        op_e        op;
        logic [3:0] dst;
        logic [3:0] src;
        logic [3:0] unused;
    } move_view_s;

    // one instruction word, two decodings
    typedef union packed {
        imm_view_s  imm;
        move_view_s mov;
    } instr_u;

    // core status seen by the supervisor
    typedef struct packed {
        logic [15:0] pc;
        logic        halted;
        logic        halt_now;
    } debug_out_s;

    // one avalon write, as held in the trace slot
    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;
    } trace_rec_s;

endpackage

`default_nettype wire

// ==== rtl/target_program.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_program (
    input  wire logic [15:0]        addr,
    output synapse_pkg::instr_u     data
);
    import synapse_pkg::*;

    // build a move-form word, unused bits zero
    function automatic instr_u mk_move(op_e op, logic [3:0] dst, logic [3:0] src);
        instr_u w;
        w.mov.is_imm = 1'b0;
        w.mov.op = op;
        w.mov.dst = dst;
        w.mov.src = src;
        w.mov.unused = 4'd0;
        return w;
    endfunction

    // build an immediate word
    function automatic instr_u mk_imm(logic [14:0] lit);
        instr_u w;
        w.imm.is_imm = 1'b1;
        w.imm.literal = lit;
        return w;
    endfunction

    always_comb begin
        case (addr)
            16'd0:   data = mk_move(OP_LOAD, 4'd0, 4'd0);
            16'd1:   data = mk_move(OP_ADD, 4'd0, 4'd1);
            16'd2:   data = mk_move(OP_STORE, 4'd2, 4'd0);
            // first trace record
            16'd3:   data = mk_move(OP_STORE, 4'(DEBUG_PEEK_REG), 4'd0);
            // read back through the peek register
            16'd4:   data = mk_move(OP_LOAD, 4'd0, 4'(DEBUG_PEEK_REG));
            16'd5:   data = mk_move(OP_XOR, 4'd0, 4'd3);
            16'd6:   data = mk_move(OP_STORE, 4'd4, 4'd0);
            16'd7:   data = mk_move(OP_SKIPZ, 4'd0, 4'd0);
            // skipped when the xor came out zero
            16'd8:   data = mk_move(OP_STORE, 4'd5, 4'd0);
            16'd9:   data = mk_move(OP_STORE, 4'(DEBUG_PEEK_REG), 4'd0);
            16'd10:  data = mk_imm(15'h0123);
            16'd11:  data = mk_move(OP_STORE, 4'd6, 4'd0);
            16'd12:  data = mk_move(OP_HALT, 4'd0, 4'd0);
            // anything past the program stops the target
            default: data = mk_move(OP_HALT, 4'd0, 4'd0);
        endcase
    end

endmodule

`default_nettype wire
